/* verilog.f */
src/mem_pkg.sv
src/sram_bank.sv
src/wb_sram_decoder.sv
src/wb_read_return.sv
src/mem_subsystem_top.sv
tb/mem_subsystem_properties.sv
tb/tb_mem_subsystem.sv

/* tb/tb_mem_subsystem.sv */
// table-driven testbench for the banked Wishbone SRAM; compile with verilog.f, top tb_mem_subsystem.

`timescale 1ns/10ps

module tb_mem_subsystem
    import mem_pkg::*;
();

    localparam int unsigned MAX_ENTRIES = 64;
    localparam int unsigned ACK_WAIT    = 8;
    localparam int unsigned ACK_LATENCY = 2;
    localparam int unsigned SWEEP       = 12;
    localparam logic [1:0]  OP_WR       = 2'd0;
    localparam logic [1:0]  OP_RD       = 2'd1;
    localparam logic [1:0]  OP_IDLE     = 2'd2;

    logic                  clock_i;
    logic                  rst_n_i;
    logic                  wb_cyc_i;
    logic                  wb_stb_i;
    logic                  wb_we_i;
    logic [ADDR_WIDTH-1:0] wb_adr_i;
    logic [DATA_WIDTH-1:0] wb_dat_i;
    logic [DATA_WIDTH-1:0] wb_dat_o;
    logic                  wb_ack_o;

    // stimulus table, one row per bus request or idle stretch.
    // for an idle row the address column holds the number of idle cycles.
    logic [1:0]            tbl_op  [MAX_ENTRIES];
    logic [ADDR_WIDTH-1:0] tbl_adr [MAX_ENTRIES];
    logic [DATA_WIDTH-1:0] tbl_dat [MAX_ENTRIES];
    logic [DATA_WIDTH-1:0] tbl_exp [MAX_ENTRIES];
    bit                    tbl_b2b [MAX_ENTRIES];
    string                 tbl_tag [MAX_ENTRIES];
    int unsigned           num_entries;
    logic [DATA_WIDTH-1:0] shadow [logic [ADDR_WIDTH-1:0]];
    int unsigned           pass_count = 0;
    int unsigned           fail_count = 0;
    int unsigned           cycle_count = 0;
    int unsigned           cycle_limit = 0;

    mem_subsystem_top u_mem_subsystem_top (.*);

    initial begin
        clock_i = 1'b0;
        forever #2 clock_i = ~clock_i;
    end

    // the run is cut off once it outlasts the table by a wide margin.
    always @(posedge clock_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // table construction
    // --------------------------------------------------

    // a write updates the shadow memory, a read takes its expected byte from it.
    function automatic void add_entry(logic [1:0] op, logic [ADDR_WIDTH-1:0] adr,
                                      logic [DATA_WIDTH-1:0] dat, bit b2b, string tag);
        tbl_op[num_entries]  = op;
        tbl_adr[num_entries] = adr;
        tbl_dat[num_entries] = dat;
        tbl_b2b[num_entries] = b2b;
        tbl_tag[num_entries] = tag;
        if (op == OP_WR) shadow[adr] = dat;
        tbl_exp[num_entries] = (op == OP_RD) ? shadow[adr] : '0;
        num_entries++;
    endfunction

    function automatic void build_table();
        logic [ADDR_WIDTH-1:0] rnd_adr [SWEEP];
        num_entries = 0;
        add_entry(OP_WR, 17'h00010, 8'ha5, 1'b0, "wr_rd");
        add_entry(OP_RD, 17'h00010, 8'h00, 1'b0, "wr_rd");
        add_entry(OP_WR, 17'h1ffff, 8'h5a, 1'b0, "wr_rd");
        add_entry(OP_RD, 17'h1ffff, 8'h00, 1'b0, "wr_rd");
        // same in-bank address in all four banks, so aliasing would show.
        for (int b = 0; b < BANK_COUNT; b++) add_entry(OP_WR, 17'h100 + b, 8'hc0 + b, 0, "interleave");
        for (int b = 0; b < BANK_COUNT; b++) add_entry(OP_RD, 17'h100 + b, 8'h00, 0, "interleave");
        // neighbours four apart sit in the same bank as the overwritten byte.
        add_entry(OP_WR, 17'h00208, 8'h11, 1'b0, "overwrite");
        add_entry(OP_WR, 17'h00204, 8'h22, 1'b0, "overwrite");
        add_entry(OP_WR, 17'h0020c, 8'h33, 1'b0, "overwrite");
        add_entry(OP_WR, 17'h00208, 8'h44, 1'b0, "overwrite");
        for (int k = 0; k < 3; k++) add_entry(OP_RD, 17'h204 + 4 * k, 8'h00, 0, "overwrite");
        add_entry(OP_IDLE, 17'd6, 8'h00, 1'b0, "idle");
        for (int b = 0; b < BANK_COUNT; b++) add_entry(OP_WR, 17'h300 + b, 8'h70 ^ b, 1, "b2b");
        for (int b = 0; b < BANK_COUNT; b++) add_entry(OP_RD, 17'h300 + b, 0, b != 3, "b2b");
        for (int k = 0; k < SWEEP; k++) begin
            rnd_adr[k] = ADDR_WIDTH'($urandom);
            add_entry(OP_WR, rnd_adr[k], DATA_WIDTH'($urandom), 1'b0, "random");
        end
        for (int k = 0; k < SWEEP; k++) add_entry(OP_RD, rnd_adr[k], 8'h00, 1'b0, "random");
    endfunction

    // --------------------------------------------------
    // bus master
    // --------------------------------------------------

    // the request is driven on one edge and sampled by the DUT on the next one.
    // the acknowledge and read byte are taken at falling edges, where they are stable.
    task automatic run_entry(input int unsigned idx, output bit ok);
        int unsigned           edges;
        bit                    acked;
        logic [DATA_WIDTH-1:0] rdata;
        ok    = 1'b1;
        edges = 0;
        acked = 1'b0;
        rdata = '0;
        if (tbl_op[idx] == OP_IDLE) begin
            repeat (tbl_adr[idx]) begin
                @(negedge clock_i);
                if (wb_ack_o) begin
                    $display("acknowledge seen while the strobe was low");
                    ok = 1'b0;
                end
            end
        end else begin
            @(posedge clock_i);
            wb_cyc_i <= 1'b1;
            wb_stb_i <= 1'b1;
            wb_we_i  <= (tbl_op[idx] == OP_WR);
            wb_adr_i <= tbl_adr[idx];
            wb_dat_i <= tbl_dat[idx];
            @(negedge clock_i);
            if (wb_ack_o) begin
                $display("acknowledge arrived before the request was sampled");
                ok = 1'b0;
            end
            while (!acked && edges < ACK_WAIT) begin
                @(posedge clock_i);
                edges++;
                @(negedge clock_i);
                acked = wb_ack_o;
                rdata = wb_dat_o;
            end
            if (!acked) begin
                $display("no acknowledge within %0d cycles for address %05h", ACK_WAIT, tbl_adr[idx]);
                ok = 1'b0;
            end
            if (acked && edges != ACK_LATENCY) begin
                $display("MISMATCH wb_ack_o latency expected %0h actual %0h", ACK_LATENCY, edges);
                ok = 1'b0;
            end
            if (acked && tbl_op[idx] == OP_RD && rdata !== tbl_exp[idx]) begin
                $display("MISMATCH wb_dat_o at %05h expected %02h actual %02h",
                         tbl_adr[idx], tbl_exp[idx], rdata);
                ok = 1'b0;
            end
            // a back-to-back row leaves the strobe up for the next request.
            if (!tbl_b2b[idx] || !acked) begin
                @(posedge clock_i);
                wb_cyc_i <= 1'b0;
                wb_stb_i <= 1'b0;
            end
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------

    initial begin
        bit ok;
        rst_n_i  = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        void'($urandom(32'he335cf6a));
        build_table();
        cycle_limit = num_entries * 8 + 100;
        repeat (5) @(posedge clock_i);
        rst_n_i <= 1'b1;
        for (int i = 0; i < num_entries; i++) begin
            run_entry(i, ok);
            if (ok) pass_count++;
            else fail_count++;
            $display("test %0d %s op=%0d adr=%05h %s", i, tbl_tag[i], tbl_op[i], tbl_adr[i],
                     ok ? "ok" : "FAILED");
        end
        $display("passed %0d, failed %0d, assertion errors %0d", pass_count, fail_count,
                 u_mem_subsystem_top.u_props.assert_errors);
        if (fail_count == 0 && u_mem_subsystem_top.u_props.assert_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_mem_subsystem

/* tb/mem_subsystem_properties.sv */
// concurrent checks on the Wishbone handshake and bank strobes, bound into mem_subsystem_top.

`timescale 1ns/10ps

module mem_subsystem_properties
    import mem_pkg::*;
(
    input logic                  clock_i,
    input logic                  rst_n_i,
    input logic                  cyc_i,
    input logic                  stb_i,
    input logic                  ack_i,
    input logic [BANK_COUNT-1:0] bank_we_n_i,
    input logic [BANK_COUNT-1:0] bank_oe_n_i,
    input logic                  issue_i
);

    // number of failed checks, read by the testbench at the end of the run.
    int unsigned assert_errors = 0;

    // --------------------------------------------------
    // strobes and acknowledge
    // --------------------------------------------------

    // only one bank may be strobed, and never for a read and a write at once.
    a_one_strobe: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        $onehot0({~bank_we_n_i, ~bank_oe_n_i}))
        else begin
            assert_errors++;
            $error("more than one bank strobe is low");
        end

    // every acknowledge is a single cycle pulse.
    a_ack_pulse: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        ack_i |=> !ack_i)
        else begin
            assert_errors++;
            $error("wb_ack_o high for two cycles");
        end

    // the acknowledge comes two edges after a request was sampled.
    a_ack_cause: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        ack_i |-> $past(cyc_i && stb_i, 2))
        else begin
            assert_errors++;
            $error("wb_ack_o without a strobed request");
        end

    // reset held across two edges keeps every strobe inactive and the acknowledge low.
    // the first edge of reset is where the control flops are known to have settled.
    a_reset_quiet: assert property (@(posedge clock_i)
        !rst_n_i ##1 !rst_n_i |-> (&bank_we_n_i && &bank_oe_n_i && !issue_i && !ack_i))
        else begin
            assert_errors++;
            $error("strobe or acknowledge during reset");
        end

endmodule : mem_subsystem_properties

bind mem_subsystem_top mem_subsystem_properties u_props (
    .clock_i     (clock_i),
    .rst_n_i     (rst_n_i),
    .cyc_i       (wb_cyc_i),
    .stb_i       (wb_stb_i),
    .ack_i       (wb_ack_o),
    .bank_we_n_i (bank_we_n),
    .bank_oe_n_i (bank_oe_n),
    .issue_i     (issue)
);

/* src/mem_subsystem_top.sv */
// top level of the banked external SRAM behind one Wishbone classic slave port; the testbench DUT.

`timescale 1ns/10ps

module mem_subsystem_top
    import mem_pkg::*;
(
    input  logic                  clock_i,
    input  logic                  rst_n_i,

    // Wishbone classic slave port, byte wide.
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [ADDR_WIDTH-1:0] wb_adr_i,
    input  logic [DATA_WIDTH-1:0] wb_dat_i,
    output logic [DATA_WIDTH-1:0] wb_dat_o,
    output logic                  wb_ack_o
);

    // --------------------------------------------------
    // internal nets
    // --------------------------------------------------

    // shared address and write data for all banks.
    logic [BANK_ADDR_WIDTH-1:0]       bank_addr;
    logic [DATA_WIDTH-1:0]            bank_wdata;

    // one active-low strobe per bank, at most one low at a time.
    logic [BANK_COUNT-1:0]            bank_we_n;
    logic [BANK_COUNT-1:0]            bank_oe_n;

    // read bytes of all banks packed side by side.
    logic [BANK_COUNT*DATA_WIDTH-1:0] bank_rdata;

    // handoff from the decoder to the return stage.
    logic                             issue;
    logic [BANK_SEL_WIDTH-1:0]        issue_bank;

    // --------------------------------------------------
    // request decoder
    // --------------------------------------------------

    // the acknowledge goes both to the port and back here to end the busy window.
    wb_sram_decoder u_decoder (
        .clock_i      (clock_i),
        .rst_n_i      (rst_n_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .ack_i        (wb_ack_o),
        .bank_addr_o  (bank_addr),
        .bank_wdata_o (bank_wdata),
        .bank_we_n_o  (bank_we_n),
        .bank_oe_n_o  (bank_oe_n),
        .issue_o      (issue),
        .issue_bank_o (issue_bank)
    );

    // --------------------------------------------------
    // interleaved banks
    // --------------------------------------------------

    // every bank sees the same address and data and acts only on its own strobes.
    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        sram_bank u_bank (
            .clock_i    (clock_i),
            .ram_addr_i (bank_addr),
            .ram_data_i (bank_wdata),
            .ram_data_o (bank_rdata[b*DATA_WIDTH +: DATA_WIDTH]),
            .ram_we_n_i (bank_we_n[b]),
            .ram_oe_n_i (bank_oe_n[b])
        );
    end

    // --------------------------------------------------
    // read return
    // --------------------------------------------------

    wb_read_return u_return (
        .clock_i      (clock_i),
        .rst_n_i      (rst_n_i),
        .issue_i      (issue),
        .issue_bank_i (issue_bank),
        .bank_rdata_i (bank_rdata),
        .wb_ack_o     (wb_ack_o),
        .wb_dat_o     (wb_dat_o)
    );

endmodule : mem_subsystem_top

/* src/wb_read_return.sv */
// return stage that selects the issued bank's read byte and raises the Wishbone acknowledge.

`timescale 1ns/10ps

module wb_read_return
    import mem_pkg::*;
(
    input  logic                             clock_i,
    input  logic                             rst_n_i,

    // issue pulse and bank index from the decoder.
    input  logic                             issue_i,
    input  logic [BANK_SEL_WIDTH-1:0]        issue_bank_i,

    // registered read bytes of all banks, bank 0 in the lowest byte.
    input  logic [BANK_COUNT*DATA_WIDTH-1:0] bank_rdata_i,

    // Wishbone classic slave response.
    output logic                             wb_ack_o,
    output logic [DATA_WIDTH-1:0]            wb_dat_o
);

    // --------------------------------------------------
    // acknowledge and bank index
    // --------------------------------------------------

    logic [BANK_SEL_WIDTH-1:0] ret_bank_q;

    // the issue pulse is delayed by one edge to form the acknowledge.
    // the banks register their read data on the same edge, so the byte
    // and the acknowledge become valid together.
    // the index is captured with the pulse and kept until the next issue,
    // so the selected byte stays stable while the master samples it.
    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o   <= 1'b0;
            ret_bank_q <= '0;
        end else begin
            wb_ack_o <= issue_i;
            if (issue_i) begin
                ret_bank_q <= issue_bank_i;
            end
        end
    end

    // --------------------------------------------------
    // read data select
    // --------------------------------------------------

    // each bank holds its last read byte, so picking the issued bank
    // is enough and no extra data register is needed here.
    // on a write acknowledge this shows a stale byte, which the master ignores.
    always_comb begin
        wb_dat_o = bank_rdata_i[ret_bank_q*DATA_WIDTH +: DATA_WIDTH];
    end

endmodule : wb_read_return

/* src/wb_sram_decoder.sv */
// Wishbone classic request decoder that strobes one SRAM bank per accepted cycle; used by the top.

`timescale 1ns/10ps

module wb_sram_decoder
    import mem_pkg::*;
(
    input  logic                       clock_i,
    input  logic                       rst_n_i,

    // Wishbone classic slave side.
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    input  logic                       wb_we_i,
    input  logic [ADDR_WIDTH-1:0]      wb_adr_i,
    input  logic [DATA_WIDTH-1:0]      wb_dat_i,

    // acknowledge coming back from the return stage.
    input  logic                       ack_i,

    // shared bank bus and per-bank active-low strobes.
    output logic [BANK_ADDR_WIDTH-1:0] bank_addr_o,
    output logic [DATA_WIDTH-1:0]      bank_wdata_o,
    output logic [BANK_COUNT-1:0]      bank_we_n_o,
    output logic [BANK_COUNT-1:0]      bank_oe_n_o,

    // issue pulse and bank index for the return stage.
    output logic                       issue_o,
    output logic [BANK_SEL_WIDTH-1:0]  issue_bank_o
);

    // --------------------------------------------------
    // request decode
    // --------------------------------------------------

    logic                       busy_q;
    logic                       req_accept;
    logic [BANK_SEL_WIDTH-1:0]  req_bank;
    logic [BANK_ADDR_WIDTH-1:0] req_addr;
    logic [BANK_COUNT-1:0]      req_onehot;
    logic [BANK_COUNT-1:0]      req_we_n;
    logic [BANK_COUNT-1:0]      req_oe_n;

    // a request is taken only while no other one is in flight.
    // a request held during the busy window is simply sampled later.
    assign req_accept = wb_cyc_i && wb_stb_i && !busy_q;

    // the low address bits pick the bank, the upper bits the byte inside it.
    assign req_bank = wb_adr_i[BANK_SEL_WIDTH-1:0];
    assign req_addr = wb_adr_i[ADDR_WIDTH-1:BANK_SEL_WIDTH];

    // one bit per bank, set for the addressed bank only.
    assign req_onehot = BANK_COUNT'(1) << req_bank;

    // a write pulls the write strobe of that bank low, a read pulls its output strobe.
    assign req_we_n = ~(req_onehot & {BANK_COUNT{wb_we_i}});
    assign req_oe_n = ~(req_onehot & {BANK_COUNT{!wb_we_i}});

    // --------------------------------------------------
    // control state
    // --------------------------------------------------

    // the strobes and the issue pulse last exactly one cycle after acceptance.
    // busy is set on acceptance and cleared on the edge that sees the acknowledge,
    // so a new request is sampled no earlier than the edge after that.
    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q       <= 1'b0;
            bank_we_n_o  <= '1;
            bank_oe_n_o  <= '1;
            issue_o      <= 1'b0;
            issue_bank_o <= '0;
        end else begin
            // strobes fall back to inactive unless a new request is taken.
            bank_we_n_o <= '1;
            bank_oe_n_o <= '1;
            issue_o     <= 1'b0;

            if (req_accept) begin
                busy_q       <= 1'b1;
                bank_we_n_o  <= req_we_n;
                bank_oe_n_o  <= req_oe_n;
                issue_o      <= 1'b1;
                issue_bank_o <= req_bank;
            end else if (ack_i) begin
                // acknowledge only arrives while busy, so the two never collide.
                busy_q <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // bank address and write data
    // --------------------------------------------------

    // payload registers are loaded with the request and held until the next one.
    // the banks only look at them while a strobe is low.
    always_ff @(posedge clock_i) begin
        if (req_accept) begin
            bank_addr_o  <= req_addr;
            bank_wdata_o <= wb_dat_i;
        end
    end

endmodule : wb_sram_decoder

/* src/sram_bank.sv */
// one byte-wide synchronous SRAM bank with active-low enables; instantiated once per bank by the top.

`timescale 1ns/10ps

module sram_bank
    import mem_pkg::*;
(
    input  logic                       clock_i,
    input  logic [BANK_ADDR_WIDTH-1:0] ram_addr_i,
    input  logic [DATA_WIDTH-1:0]      ram_data_i,
    output logic [DATA_WIDTH-1:0]      ram_data_o,
    input  logic                       ram_we_n_i,
    input  logic                       ram_oe_n_i
);

    // --------------------------------------------------
    // storage
    // --------------------------------------------------

    // the contents are undefined after power-up.
    // the bus master is expected to write a location before reading it.
    logic [DATA_WIDTH-1:0] mem [BANK_DEPTH];

    // --------------------------------------------------
    // access port
    // --------------------------------------------------

    // a single port serves both directions.
    // a low write enable stores the input byte at the addressed location.
    // otherwise a low output enable copies the addressed byte to the output register.
    // write wins if both enables are low, though the decoder never asserts both.
    always_ff @(posedge clock_i) begin
        if (!ram_we_n_i) begin
            mem[ram_addr_i] <= ram_data_i;
        end else if (!ram_oe_n_i) begin
            ram_data_o <= mem[ram_addr_i];
        end
    end

    // the output register keeps the last byte read while the bank is idle.
    // the return stage samples it in the cycle after the read strobe,
    // which is the same cycle in which the acknowledge is high.
    // a write leaves the output register untouched, so a write to a bank
    // does not disturb the byte it returned on its previous read.

endmodule : sram_bank

/* src/mem_pkg.sv */
// memory map constants shared by the SRAM subsystem RTL and its testbench; import with mem_pkg::*.

package mem_pkg;

    // --------------------------------------------------
    // bus geometry
    // --------------------------------------------------

    // the full byte address as seen on the Wishbone port.
    // 17 bits cover the 128 KiB external SRAM.
    localparam int unsigned ADDR_WIDTH = 17;

    // the bus is one byte wide, so there are no byte selects.
    localparam int unsigned DATA_WIDTH = 8;

    // --------------------------------------------------
    // bank split
    // --------------------------------------------------

    // the memory is made of four interleaved banks.
    localparam int unsigned BANK_COUNT = 4;

    // the lowest address bits pick the bank.
    // consecutive byte addresses therefore land in consecutive banks.
    localparam int unsigned BANK_SEL_WIDTH = 2;

    // the remaining upper address bits index a byte inside one bank.
    localparam int unsigned BANK_ADDR_WIDTH = ADDR_WIDTH - BANK_SEL_WIDTH;

    // bytes held by each bank, 32768 for the 15 bit in-bank address.
    localparam int unsigned BANK_DEPTH = 2 ** BANK_ADDR_WIDTH;

endpackage : mem_pkg
